// ==== verilog.f ====
+incdir+include
src/timestamp_pkg.sv
src/axi_lite_slave.sv
src/timestamp_regs.sv
src/stamp_counter.sv
src/timestamp_top.sv
test/timestamp_tb.sv

// ==== test/timestamp_tb.sv ====
// Table-driven testbench for the timestamp peripheral
// AXI4-Lite bus tasks, typed compare tasks, cycle-count timeout

`default_nettype none

`include "timestamp_consts.svh"

module timestamp_tb;

  localparam logic [2:0]  K_WR   = 3'd0;
  localparam logic [2:0]  K_RD   = 3'd1;
  localparam logic [2:0]  K_STEP = 3'd2;
  localparam logic [2:0]  K_SNAP = 3'd3;
  localparam logic [2:0]  K_PPS  = 3'd4;
  localparam int          N_TESTS    = 23;
  localparam int unsigned MAX_CYCLES = 4000;

  typedef struct packed {
    logic [2:0]               kind;
    timestamp_pkg::axi_addr_t addr;
    timestamp_pkg::axi_data_t data;
    timestamp_pkg::axi_data_t exp;
    timestamp_pkg::axi_resp_t resp;
  } entry_t;

  // kind, address, write data or cycle count, expected read data, expected response
  entry_t tests [N_TESTS] = '{
    '{K_WR,   `REG_NTP_LO,   32'hFFFF_FF00, 32'h0,          `RESP_OKAY},
    '{K_WR,   `REG_NTP_HI,   32'h0000_1234, 32'h0,          `RESP_OKAY},
    '{K_RD,   `REG_NTP_LO,   32'h0,         32'hFFFF_FF00, `RESP_OKAY},
    '{K_RD,   `REG_NTP_HI,   32'h0,         32'h0000_1234, `RESP_OKAY},
    '{K_WR,   `REG_CTRL,     32'h2,         32'h0,          `RESP_OKAY},
    '{K_RD,   `REG_CTRL,     32'h0,         32'h2,          `RESP_OKAY},
    '{K_WR,   `REG_CTRL,     32'h1,         32'h0,          `RESP_OKAY},
    '{K_STEP, 32'h0,         32'd20,        32'h0,          `RESP_OKAY},
    '{K_RD,   `REG_CTRL,     32'h0,         32'h0,          `RESP_OKAY},
    '{K_SNAP, 32'h0,         32'h0,         32'h0,          `RESP_OKAY},
    '{K_WR,   `REG_CTRL,     32'h3,         32'h0,          `RESP_OKAY},
    '{K_RD,   `REG_CTRL,     32'h0,         32'h2,          `RESP_OKAY},
    '{K_PPS,  32'h0,         32'h1,         32'h0,          `RESP_OKAY},
    '{K_SNAP, 32'h0,         32'h0,         32'h0,          `RESP_OKAY},
    '{K_WR,   `REG_CTRL,     32'h0,         32'h0,          `RESP_OKAY},
    '{K_PPS,  32'h0,         32'h0,         32'h0,          `RESP_OKAY},
    // Seconds roll over between the two snapshot reads
    '{K_WR,   `REG_NTP_LO,   32'hFFFF_FE80, 32'h0,          `RESP_OKAY},
    '{K_WR,   `REG_CTRL,     32'h1,         32'h0,          `RESP_OKAY},
    '{K_SNAP, 32'h0,         32'd6,         32'h0,          `RESP_OKAY},
    '{K_RD,   32'h14,        32'h0,         32'h0,          `RESP_SLVERR},
    '{K_WR,   `REG_STAMP_LO, 32'hDEAD_BEEF, 32'h0,          `RESP_SLVERR},
    '{K_WR,   `REG_STAMP_HI, 32'hDEAD_BEEF, 32'h0,          `RESP_SLVERR},
    '{K_RD,   32'h40,        32'h0,         32'h0,          `RESP_SLVERR}
  };

  logic                     axi_aclk;
  logic                     rst_n;
  timestamp_pkg::axi_addr_t awaddr;
  logic                     awvalid;
  logic                     awready;
  timestamp_pkg::axi_data_t wdata;
  timestamp_pkg::axi_strb_t wstrb;
  logic                     wvalid;
  logic                     wready;
  timestamp_pkg::axi_resp_t bresp;
  logic                     bvalid;
  logic                     bready;
  timestamp_pkg::axi_addr_t araddr;
  logic                     arvalid;
  logic                     arready;
  timestamp_pkg::axi_data_t rdata;
  timestamp_pkg::axi_resp_t rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     clk_correction;
  timestamp_pkg::stamp_t    stamp_counter;

  int unsigned cyc = 0;
  // Cycle in which the last write took effect, and the last read ack cycle
  int unsigned wr_cyc;
  int unsigned rd_cyc;

  timestamp_top timestamp_top_i (
    .axi_aclk       (axi_aclk),
    .rst_n          (rst_n),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .clk_correction (clk_correction),
    .stamp_counter  (stamp_counter)
  );

  always #5 axi_aclk = ~axi_aclk;

  always @(posedge axi_aclk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      stop_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Inputs change and outputs are sampled 1 unit after the rising edge
  task automatic tick();
    @(posedge axi_aclk);
    #1;
  endtask

  // Expected time after a number of free-running cycles
  function automatic timestamp_pkg::stamp_t advance(input timestamp_pkg::stamp_t base,
                                                    input int unsigned cycles);
    return base + timestamp_pkg::stamp_t'(cycles) * timestamp_pkg::stamp_t'(`TS_STEP);
  endfunction

  task automatic check_data(input string name, input timestamp_pkg::axi_data_t exp,
                            input timestamp_pkg::axi_data_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input timestamp_pkg::axi_resp_t exp,
                            input timestamp_pkg::axi_resp_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_stamp(input string name, input timestamp_pkg::stamp_t exp,
                             input timestamp_pkg::stamp_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic axi_write(input timestamp_pkg::axi_addr_t addr,
                           input timestamp_pkg::axi_data_t data,
                           output timestamp_pkg::axi_resp_t resp);
    int unsigned delay;
    delay   = $urandom % 4;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      tick();
    end while (!awready);
    if (!wready) begin
      stop_run("wready did not rise together with awready");
    end
    tick();
    wr_cyc  = cyc;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      tick();
    end
    repeat (delay) begin
      tick();
      if (!bvalid) begin
        stop_run("bvalid dropped while bready was held low");
      end
    end
    bready = 1'b1;
    resp   = bresp;
    tick();
    bready = 1'b0;
  endtask

  task automatic axi_read(input timestamp_pkg::axi_addr_t addr,
                          output timestamp_pkg::axi_data_t data,
                          output timestamp_pkg::axi_resp_t resp);
    int unsigned delay;
    delay   = $urandom % 4;
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      tick();
    end while (!arready);
    rd_cyc = cyc;
    tick();
    arvalid = 1'b0;
    while (!rvalid) begin
      tick();
    end
    repeat (delay) begin
      tick();
      if (!rvalid) begin
        stop_run("rvalid dropped while rready was held low");
      end
    end
    rready = 1'b1;
    data   = rdata;
    resp   = rresp;
    tick();
    rready = 1'b0;
  endtask

  initial begin
    entry_t                   t;
    timestamp_pkg::stamp_t    ntp_v;
    timestamp_pkg::stamp_t    s0;
    timestamp_pkg::axi_data_t lo;
    timestamp_pkg::axi_data_t hi;
    timestamp_pkg::axi_resp_t resp;
    int unsigned              c0;
    int unsigned              c1;
    void'($urandom(11000));
    axi_aclk       = 1'b0;
    rst_n          = 1'b0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    clk_correction = 1'b0;
    ntp_v          = '0;
    repeat (16) tick();
    if (awready || wready || arready || bvalid || rvalid) begin
      stop_run("A ready or valid output was high during reset");
    end
    check_stamp("stamp_counter", '0, stamp_counter);
    rst_n = 1'b1;
    tick();

    for (int i = 0; i < N_TESTS; i++) begin
      t = tests[i];
      case (t.kind)
        K_WR: begin
          axi_write(t.addr, t.data, resp);
          check_resp("bresp", t.resp, resp);
          if (t.addr[7:0] == `REG_NTP_LO) begin
            ntp_v[31:0] = t.data;
          end else if (t.addr[7:0] == `REG_NTP_HI) begin
            ntp_v[63:32] = t.data;
          end
        end
        K_RD: begin
          axi_read(t.addr, lo, resp);
          check_resp("rresp", t.resp, resp);
          check_data("rdata", t.exp, lo);
        end
        K_STEP: begin
          // Load value appears at the edge that closes the write handshake
          s0 = stamp_counter;
          c0 = cyc;
          check_stamp("stamp_counter", advance(ntp_v, c0 - wr_cyc), s0);
          repeat (t.data) tick();
          check_stamp("stamp_counter", advance(s0, cyc - c0), stamp_counter);
        end
        K_SNAP: begin
          // A nonzero count starts the reads that many cycles after the last write
          while (cyc - wr_cyc < t.data) begin
            tick();
          end
          s0 = stamp_counter;
          c0 = cyc;
          axi_read(`REG_STAMP_LO, lo, resp);
          check_resp("rresp", `RESP_OKAY, resp);
          c1 = rd_cyc;
          axi_read(`REG_STAMP_HI, hi, resp);
          check_resp("rresp", `RESP_OKAY, resp);
          check_stamp("snapshot", advance(s0, c1 - c0), {hi, lo});
          check_stamp("stamp_counter", advance(s0, cyc - c0), stamp_counter);
        end
        K_PPS: begin
          s0 = stamp_counter;
          c0 = cyc;
          clk_correction = 1'b1;
          tick();
          clk_correction = 1'b0;
          if (t.data[0]) begin
            s0 = {s0[63:32] + 32'd1, 32'd0};
            c0 = cyc;
          end
          repeat (5) tick();
          check_stamp("stamp_counter", advance(s0, cyc - c0), stamp_counter);
        end
        default: begin
          stop_run("Unknown operation in the test table");
        end
      endcase
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/timestamp_top.sv ====
// Timestamp peripheral top: AXI4-Lite slave, register bank, counter

`default_nettype none

module timestamp_top (
  input  logic                     axi_aclk,
  input  logic                     rst_n,

  // AXI4-Lite slave port
  input  timestamp_pkg::axi_addr_t awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  timestamp_pkg::axi_data_t wdata,
  input  timestamp_pkg::axi_strb_t wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output timestamp_pkg::axi_resp_t bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  timestamp_pkg::axi_addr_t araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output timestamp_pkg::axi_data_t rdata,
  output timestamp_pkg::axi_resp_t rresp,
  output logic                     rvalid,
  input  logic                     rready,

  // Pulse per second
  input  logic                     clk_correction,

  // Raw time for the packet pipeline
  output timestamp_pkg::stamp_t    stamp_counter
);

  timestamp_pkg::reg_req_t   reg_req;
  timestamp_pkg::reg_rsp_t   reg_rsp;
  timestamp_pkg::time_ctrl_t time_ctrl;

  axi_lite_slave axi_lite_slave_i (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .reg_req  (reg_req),
    .reg_rsp  (reg_rsp)
  );

  timestamp_regs timestamp_regs_i (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .reg_req   (reg_req),
    .stamp     (stamp_counter),
    .reg_rsp   (reg_rsp),
    .time_ctrl (time_ctrl)
  );

  stamp_counter stamp_counter_i (
    .axi_aclk       (axi_aclk),
    .rst_n          (rst_n),
    .clk_correction (clk_correction),
    .time_ctrl      (time_ctrl),
    .stamp          (stamp_counter)
  );

endmodule

`default_nettype wire

// ==== src/stamp_counter.sv ====
// NTP-format time counter
// Load, pulse-per-second snap to next second, fixed per-cycle step

`default_nettype none

`include "timestamp_consts.svh"

module stamp_counter (
  input  logic                      axi_aclk,
  input  logic                      rst_n,
  input  logic                      clk_correction,
  input  timestamp_pkg::time_ctrl_t time_ctrl,
  output timestamp_pkg::stamp_t     stamp
);

  timestamp_pkg::stamp_t  stamp_q;
  timestamp_pkg::stamp_t  stamp_nxt;
  logic [`TS_W/2-1:0]     seconds;
  logic                   snap;

  assign seconds = stamp_q[`TS_W-1:`TS_W/2];

  // Correction only counts while enabled
  assign snap = time_ctrl.pps_en && clk_correction;

  // Load first, then the PPS snap, else free running
  always_comb begin
    if (time_ctrl.load) begin
      stamp_nxt = time_ctrl.ntp;
    end else if (snap) begin
      stamp_nxt = {seconds + 1'b1, {(`TS_W/2){1'b0}}};
    end else begin
      stamp_nxt = stamp_q + timestamp_pkg::stamp_t'(`TS_STEP);
    end
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_nxt;
    end
  end

  assign stamp = stamp_q;

  // Free-running steps carry into the seconds
  a_step: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    !time_ctrl.load && !snap
      |=> stamp == $past(stamp) + timestamp_pkg::stamp_t'(`TS_STEP))
    else $error("stamp did not advance by one step");

endmodule

`default_nettype wire

// ==== src/timestamp_regs.sv ====
// Register bank: control, NTP load value, stamp snapshot
// Address decode and the one-cycle load strobe

`default_nettype none

`include "timestamp_consts.svh"

module timestamp_regs (
  input  logic                       axi_aclk,
  input  logic                       rst_n,
  input  timestamp_pkg::reg_req_t    reg_req,
  input  timestamp_pkg::stamp_t      stamp,
  output timestamp_pkg::reg_rsp_t    reg_rsp,
  output timestamp_pkg::time_ctrl_t  time_ctrl
);

  logic [7:0]               off;
  logic                     wr_ctrl;
  logic                     wr_ntp_lo;
  logic                     wr_ntp_hi;
  logic                     rd_stamp_lo;
  logic                     pps_en_q;
  timestamp_pkg::stamp_t    ntp_q;
  timestamp_pkg::axi_data_t stamp_hi_q;

  // Merge the strobed bytes of a write into a word
  function automatic timestamp_pkg::axi_data_t merge_strb(
    input timestamp_pkg::axi_data_t old_word,
    input timestamp_pkg::axi_data_t new_word,
    input timestamp_pkg::axi_strb_t strb
  );
    timestamp_pkg::axi_data_t word;
    word = old_word;
    for (int i = 0; i < `AXI_DATA_W / 8; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return word;
  endfunction

  assign off         = reg_req.addr[7:0];
  assign wr_ctrl     = reg_req.wr && (off == `REG_CTRL);
  assign wr_ntp_lo   = reg_req.wr && (off == `REG_NTP_LO);
  assign wr_ntp_hi   = reg_req.wr && (off == `REG_NTP_HI);
  assign rd_stamp_lo = reg_req.rd && (off == `REG_STAMP_LO);

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      pps_en_q <= 1'b0;
      ntp_q    <= '0;
    end else begin
      if (wr_ctrl && reg_req.strb[0]) begin
        pps_en_q <= reg_req.wdata[1];
      end
      if (wr_ntp_lo) begin
        ntp_q[`AXI_DATA_W-1:0] <= merge_strb(ntp_q[`AXI_DATA_W-1:0],
                                             reg_req.wdata, reg_req.strb);
      end
      if (wr_ntp_hi) begin
        ntp_q[`TS_W-1:`AXI_DATA_W] <= merge_strb(ntp_q[`TS_W-1:`AXI_DATA_W],
                                                 reg_req.wdata, reg_req.strb);
      end
    end
  end

  // Upper word frozen when the low word is read
  always_ff @(posedge axi_aclk) begin
    if (rd_stamp_lo) begin
      stamp_hi_q <= stamp[`TS_W-1:`AXI_DATA_W];
    end
  end

  // Load bit is a strobe, never stored
  always_comb begin
    time_ctrl.load   = wr_ctrl && reg_req.strb[0] && reg_req.wdata[0];
    time_ctrl.pps_en = pps_en_q;
    time_ctrl.ntp    = ntp_q;
  end

  always_comb begin
    reg_rsp.rdata = '0;
    reg_rsp.err   = 1'b0;
    case (off)
      `REG_CTRL: begin
        reg_rsp.rdata[1] = pps_en_q;
      end
      `REG_NTP_LO: begin
        reg_rsp.rdata = ntp_q[`AXI_DATA_W-1:0];
      end
      `REG_NTP_HI: begin
        reg_rsp.rdata = ntp_q[`TS_W-1:`AXI_DATA_W];
      end
      `REG_STAMP_LO: begin
        reg_rsp.rdata = stamp[`AXI_DATA_W-1:0];
        reg_rsp.err   = reg_req.wr;
      end
      `REG_STAMP_HI: begin
        reg_rsp.rdata = stamp_hi_q;
        reg_rsp.err   = reg_req.wr;
      end
      default: begin
        reg_rsp.err = 1'b1;
      end
    endcase
  end

  a_load_pulse: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    time_ctrl.load |=> !time_ctrl.load)
    else $error("load strobe held longer than one cycle");

endmodule

`default_nettype wire

// ==== src/axi_lite_slave.sv ====
// AXI4-Lite slave, one transaction at a time
// Issues single-cycle register requests and returns latched responses

`default_nettype none

`include "timestamp_consts.svh"

module axi_lite_slave (
  input  logic                     axi_aclk,
  input  logic                     rst_n,

  // Write address and data channels
  input  timestamp_pkg::axi_addr_t awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  timestamp_pkg::axi_data_t wdata,
  input  timestamp_pkg::axi_strb_t wstrb,
  input  logic                     wvalid,
  output logic                     wready,

  // Write response channel
  output timestamp_pkg::axi_resp_t bresp,
  output logic                     bvalid,
  input  logic                     bready,

  // Read address and data channels
  input  timestamp_pkg::axi_addr_t araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output timestamp_pkg::axi_data_t rdata,
  output timestamp_pkg::axi_resp_t rresp,
  output logic                     rvalid,
  input  logic                     rready,

  // Register bank side
  output timestamp_pkg::reg_req_t  reg_req,
  input  timestamp_pkg::reg_rsp_t  reg_rsp
);

  timestamp_pkg::slave_state_t state;
  timestamp_pkg::slave_state_t state_nxt;
  timestamp_pkg::axi_data_t    rdata_q;
  timestamp_pkg::axi_resp_t    resp_q;

  always_comb begin
    state_nxt = state;
    case (state)
      timestamp_pkg::IDLE: begin
        // Read wins when both are pending
        if (arvalid) begin
          state_nxt = timestamp_pkg::RD_ACK;
        end else if (awvalid && wvalid) begin
          state_nxt = timestamp_pkg::WR_ACK;
        end
      end
      timestamp_pkg::WR_ACK: begin
        state_nxt = timestamp_pkg::WR_RESP;
      end
      timestamp_pkg::WR_RESP: begin
        if (bready) begin
          state_nxt = timestamp_pkg::IDLE;
        end
      end
      timestamp_pkg::RD_ACK: begin
        state_nxt = timestamp_pkg::RD_DATA;
      end
      timestamp_pkg::RD_DATA: begin
        if (rready) begin
          state_nxt = timestamp_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = timestamp_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= timestamp_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Handshakes decoded straight from the state
  assign awready = (state == timestamp_pkg::WR_ACK);
  assign wready  = (state == timestamp_pkg::WR_ACK);
  assign arready = (state == timestamp_pkg::RD_ACK);
  assign bvalid  = (state == timestamp_pkg::WR_RESP);
  assign rvalid  = (state == timestamp_pkg::RD_DATA);

  // Request lives in the ack cycle only
  always_comb begin
    reg_req.wr    = awready;
    reg_req.rd    = arready;
    reg_req.addr  = arready ? araddr : awaddr;
    reg_req.wdata = wdata;
    reg_req.strb  = wstrb;
  end

  // Same response register serves both channels
  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q <= `RESP_OKAY;
    end else if (awready || arready) begin
      resp_q <= reg_rsp.err ? `RESP_SLVERR : `RESP_OKAY;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (arready) begin
      rdata_q <= reg_rsp.rdata;
    end
  end

  assign bresp = resp_q;
  assign rresp = resp_q;
  assign rdata = rdata_q;

  a_bvalid_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid dropped or bresp changed before bready");

  a_rvalid_hold: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid dropped or read data changed before rready");

  a_req_onehot: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    !(reg_req.wr && reg_req.rd))
    else $error("write and read request in the same cycle");

endmodule

`default_nettype wire

// ==== src/timestamp_pkg.sv ====
// Shared types: bus vectors, NTP stamp, request/response structs
// and the bus slave state enum

`default_nettype none

`include "timestamp_consts.svh"

package timestamp_pkg;

  typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [1:0]               axi_resp_t;

  // Seconds in the upper half
  typedef logic [`TS_W-1:0] stamp_t;

  // Slave to register bank, valid only while wr or rd is high
  typedef struct packed {
    logic      wr;
    logic      rd;
    axi_addr_t addr;
    axi_data_t wdata;
    axi_strb_t strb;
  } reg_req_t;

  typedef struct packed {
    axi_data_t rdata;
    logic      err;
  } reg_rsp_t;

  typedef struct packed {
    logic   load;
    logic   pps_en;
    stamp_t ntp;
  } time_ctrl_t;

  typedef enum logic [2:0] {
    IDLE,
    WR_ACK,
    WR_RESP,
    RD_ACK,
    RD_DATA
  } slave_state_t;

endpackage

`default_nettype wire

// ==== include/timestamp_consts.svh ====
// Bus and timestamp widths, per-cycle step
// Register offsets and AXI response codes

`ifndef TIMESTAMP_CONSTS_SVH
`define TIMESTAMP_CONSTS_SVH

// AXI4-Lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// NTP time, 32 bits seconds over 32 bits fraction
`define TS_W 64
// 2^32 / 100 MHz, rounded
`define TS_STEP 43

// Register offsets, low address byte only
`define REG_CTRL     8'h00
`define REG_NTP_LO   8'h04
`define REG_NTP_HI   8'h08
`define REG_STAMP_LO 8'h0C
`define REG_STAMP_HI 8'h10

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif
